/* design/fp_addsub.sv */
// Binary32 add/subtract core with renormalization and five rounding modes
// NaN and infinity operands are left to fp_special_case at the same level
`default_nettype none

module fp_addsub
  import fp_types_pkg::*;
  import fp_ctrl_pkg::*;
(
  input  fp32_t   a_i,
  input  fp32_t   b_i,
  input  logic    sub_i,    // Flips the sign of b
  input  frm_e    frm_i,
  output fp32_t   result_o,
  output fflags_t fflags_o
);

  localparam int unsigned SUM_W = FP_MANT_EXT_W + 1; // Carry bit on top
  localparam int unsigned POS_W = $clog2(SUM_W);

  fp_exp_t          exp_c;                // Common exponent after alignment
  logic             a_sign, b_sign;
  fp_mant_ext_t     a_mant, b_mant;
  fp_mant_ext_t     mant_big, mant_small;
  logic             b_sign_eff;
  logic             eff_sub;              // Signs differ after sub_i
  logic             a_ge_b;
  logic             res_sign;
  logic             zero_sign;
  logic [SUM_W-1:0] sum;
  logic [POS_W-1:0] lead_pos;
  logic             sum_zero;

  logic [8:0]         lshift_want, lshift_max, lshift;
  logic [9:0]         norm_exp;           // Wide enough for carry and overflow
  fp_mant_ext_t       norm_mant;          // Hidden bit at the MSB when normal
  logic [FP_FRAC_W:0] mant_keep;          // Hidden bit plus fraction
  logic               last, guard, sticky, inexact;
  logic               round_up, reserved;
  logic [FP_FRAC_W+1:0] rounded;
  logic               rnd_carry;
  logic [9:0]         rnd_exp;
  fp_frac_t           rnd_frac;
  logic               is_normal, overflow;

  fp_align u_align (
    .a_i      (a_i),
    .b_i      (b_i),
    .exp_o    (exp_c),
    .a_sign_o (a_sign),
    .b_sign_o (b_sign),
    .a_mant_o (a_mant),
    .b_mant_o (b_mant)
  );

  assign b_sign_eff = b_sign ^ sub_i;
  assign eff_sub    = a_sign ^ b_sign_eff;

  // Magnitude compare so that subtraction never goes negative
  assign a_ge_b     = a_mant >= b_mant;
  assign mant_big   = a_ge_b ? a_mant : b_mant;
  assign mant_small = a_ge_b ? b_mant : a_mant;
  assign res_sign   = a_ge_b ? a_sign : b_sign_eff;

  assign sum = eff_sub ? {1'b0, mant_big} - {1'b0, mant_small}
                       : {1'b0, mant_big} + {1'b0, mant_small};

  fp_lead_one #(
    .WIDTH (SUM_W)
  ) u_lead_one (
    .vec_i  (sum),
    .pos_o  (lead_pos),
    .zero_o (sum_zero)
  );

  // Sign of an exact zero depends on the mode only after cancellation
  assign zero_sign = eff_sub ? (frm_i == RDN) : a_sign;

  // Renormalize without going below effective exponent 1
  always_comb begin
    lshift_want = 9'(SUM_W - 2) - 9'(lead_pos);
    lshift_max  = 9'(exp_c) - 9'd1;
    lshift      = (lshift_want > lshift_max) ? lshift_max : lshift_want;
    if (sum[SUM_W-1]) begin
      norm_mant = {sum[SUM_W-1:2], |sum[1:0]}; // Carry out needs one right shift
      norm_exp  = 10'(exp_c) + 10'd1;
    end else begin
      norm_mant = sum[FP_MANT_EXT_W-1:0] << lshift;
      norm_exp  = 10'(exp_c) - 10'(lshift);
    end
  end

  assign mant_keep = norm_mant[FP_MANT_EXT_W-1:FP_GRS_W];
  assign last      = norm_mant[FP_GRS_W];
  assign guard     = norm_mant[FP_GRS_W-1];
  assign sticky    = |norm_mant[FP_GRS_W-2:0];
  assign inexact   = guard | sticky;

  always_comb begin
    round_up = 1'b0;
    reserved = 1'b0;
    case (frm_i)
      RNE:     round_up = guard & (sticky | last);
      RTZ:     round_up = 1'b0;
      RDN:     round_up = res_sign & inexact;
      RUP:     round_up = ~res_sign & inexact;
      RMM:     round_up = guard;
      default: reserved = 1'b1; // Codes 5 to 7
    endcase
  end

  assign rounded   = {1'b0, mant_keep} + (FP_FRAC_W+2)'(round_up);
  assign rnd_carry = rounded[FP_FRAC_W+1];             // Mantissa wrapped to 2.0
  assign rnd_exp   = norm_exp + 10'(rnd_carry);
  assign rnd_frac  = rnd_carry ? rounded[FP_FRAC_W:1] : rounded[FP_FRAC_W-1:0];
  assign is_normal = rnd_carry | rounded[FP_FRAC_W];   // Subnormal may round up to normal
  assign overflow  = is_normal & (rnd_exp >= 10'(FP_EXP_MAX));

  always_comb begin
    fflags_o = '0;
    if (reserved) begin
      result_o          = FP_QNAN;
      fflags_o[FLAG_NV] = 1'b1;
    end else if (sum_zero) begin
      result_o = {zero_sign, {(FP_WORD_W-1){1'b0}}}; // Exact zero
    end else if (overflow) begin
      result_o          = {res_sign, FP_EXP_MAX, fp_frac_t'(0)};
      fflags_o[FLAG_OF] = 1'b1;
      fflags_o[FLAG_NX] = 1'b1;
    end else begin
      result_o          = {res_sign, is_normal ? rnd_exp[FP_EXP_W-1:0] : fp_exp_t'(0), rnd_frac};
      fflags_o[FLAG_UF] = ~is_normal & inexact; // Tiny after rounding
      fflags_o[FLAG_NX] = inexact;
    end
  end

  // An overflowed result is never exact
  always_comb begin
    assert final (!fflags_o[FLAG_OF] || fflags_o[FLAG_NX])
      else $error("OF raised without NX");
  end

endmodule

`default_nettype wire

/* design/fp_align.sv */
// Unpacks two binary32 operands and aligns them to a common exponent
// Feeds the add/sub core with hidden bit restored and sticky collected
`default_nettype none

module fp_align
  import fp_types_pkg::*;
(
  input  fp32_t        a_i,
  input  fp32_t        b_i,
  output fp_exp_t      exp_o,    // Larger of the two exponents
  output logic         a_sign_o,
  output logic         b_sign_o,
  output fp_mant_ext_t a_mant_o,
  output fp_mant_ext_t b_mant_o
);

  logic         a_hid, b_hid;        // Hidden bit, zero for subnormals
  fp_exp_t      a_exp, b_exp;        // Effective exponents
  fp_exp_t      exp_diff;
  fp_mant_ext_t a_full, b_full;
  fp_mant_ext_t small_mant;
  fp_mant_ext_t small_shift;
  fp_mant_ext_t lost_mask;           // Bits pushed out by the right shift
  logic         a_larger;
  logic         sticky;

  assign a_hid = |a_i[FP_FRAC_W +: FP_EXP_W];
  assign b_hid = |b_i[FP_FRAC_W +: FP_EXP_W];

  // Subnormals sit at exponent 1 without the hidden bit
  assign a_exp = a_hid ? a_i[FP_FRAC_W +: FP_EXP_W] : fp_exp_t'(1);
  assign b_exp = b_hid ? b_i[FP_FRAC_W +: FP_EXP_W] : fp_exp_t'(1);

  assign a_full = {a_hid, fp_frac_t'(a_i), {FP_GRS_W{1'b0}}};
  assign b_full = {b_hid, fp_frac_t'(b_i), {FP_GRS_W{1'b0}}};

  assign a_larger   = a_exp >= b_exp;
  assign exp_diff   = a_larger ? a_exp - b_exp : b_exp - a_exp;
  assign small_mant = a_larger ? b_full : a_full;

  // A shift of the full width or more gives an all-ones mask
  assign lost_mask   = (fp_mant_ext_t'(1) << exp_diff) - fp_mant_ext_t'(1);
  assign sticky      = |(small_mant & lost_mask);
  assign small_shift = (small_mant >> exp_diff) | fp_mant_ext_t'(sticky);

  assign exp_o    = a_larger ? a_exp : b_exp;
  assign a_sign_o = a_i[FP_WORD_W-1];
  assign b_sign_o = b_i[FP_WORD_W-1];
  assign a_mant_o = a_larger ? a_full : small_shift;
  assign b_mant_o = a_larger ? small_shift : b_full;

endmodule

`default_nettype wire

/* design/fp_ctrl_pkg.sv */
// Rounding modes and exception flag layout of the F-extension control path
// Imported by the core, the special-case block and the top level
`default_nettype none

package fp_ctrl_pkg;

  // Rounding mode field, codes 5 to 7 are reserved
  typedef enum logic [2:0] {
    RNE = 3'b000, // Nearest, ties to even
    RTZ = 3'b001, // Toward zero
    RDN = 3'b010, // Toward minus infinity
    RUP = 3'b011, // Toward plus infinity
    RMM = 3'b100  // Nearest, ties to max magnitude
  } frm_e;

  // Exception flags, NV in the MSB down to NX in the LSB
  typedef logic [4:0] fflags_t;

  localparam int unsigned FLAG_NV = 4; // Invalid operation
  localparam int unsigned FLAG_DZ = 3; // Divide by zero, never raised here
  localparam int unsigned FLAG_OF = 2; // Overflow
  localparam int unsigned FLAG_UF = 1; // Underflow
  localparam int unsigned FLAG_NX = 0; // Inexact

endpackage

`default_nettype wire

/* design/fp_lead_one.sv */
// Priority encoder giving the index of the highest set bit of a vector
// Used by the add/sub core to find the shift needed for renormalization
`default_nettype none

module fp_lead_one #(
  parameter  int unsigned WIDTH = 28,
  localparam int unsigned POS_W = $clog2(WIDTH)
) (
  input  logic [WIDTH-1:0] vec_i,
  output logic [POS_W-1:0] pos_o,  // Index of the leading one
  output logic             zero_o  // No bit set at all
);

  // Scan upward so that the highest set bit is the last one to win
  always_comb begin
    pos_o = '0;
    for (int i = 0; i < WIDTH; i++) begin
      if (vec_i[i]) begin
        pos_o = POS_W'(i);
      end
    end
  end

  assign zero_o = ~|vec_i; // Position is meaningless in this case

  // Reported position must point at a one
  always_comb begin
    if (!zero_o) begin
      assert final (vec_i[pos_o])
        else $error("leading-one position %0d not set in %h", pos_o, vec_i);
    end
  end

endmodule

`default_nettype wire

/* design/fp_special_case.sv */
// Resolves NaN and infinity operands of an add/sub around the arithmetic core
// Passes the core result through when both operands are finite
`default_nettype none

module fp_special_case
  import fp_types_pkg::*;
  import fp_ctrl_pkg::*;
(
  input  fp32_t   a_i,
  input  fp32_t   b_i,
  input  logic    sub_i,
  input  fp32_t   core_result_i,
  input  fflags_t core_fflags_i,
  output fp32_t   result_o,
  output fflags_t fflags_o
);

  logic a_exp_max, b_exp_max;   // Exponent all ones
  logic a_frac_nz, b_frac_nz;
  logic a_nan, b_nan;
  logic a_snan, b_snan;         // Quiet bit clear
  logic a_inf, b_inf;
  logic a_sign, b_sign_eff;

  assign a_exp_max = fp_exp_t'(a_i >> FP_FRAC_W) == FP_EXP_MAX;
  assign b_exp_max = fp_exp_t'(b_i >> FP_FRAC_W) == FP_EXP_MAX;
  assign a_frac_nz = |fp_frac_t'(a_i);
  assign b_frac_nz = |fp_frac_t'(b_i);

  assign a_nan  = a_exp_max & a_frac_nz;
  assign b_nan  = b_exp_max & b_frac_nz;
  assign a_snan = a_nan & ~a_i[FP_FRAC_W-1];
  assign b_snan = b_nan & ~b_i[FP_FRAC_W-1];
  assign a_inf  = a_exp_max & ~a_frac_nz;
  assign b_inf  = b_exp_max & ~b_frac_nz;

  assign a_sign     = a_i[FP_WORD_W-1];
  assign b_sign_eff = b_i[FP_WORD_W-1] ^ sub_i; // Sign as seen by the addition

  always_comb begin
    result_o = core_result_i;
    fflags_o = core_fflags_i;
    if (a_nan || b_nan) begin
      result_o          = FP_QNAN;
      fflags_o          = '0;
      fflags_o[FLAG_NV] = a_snan | b_snan; // Quiet NaNs propagate silently
    end else if (a_inf && b_inf && (a_sign != b_sign_eff)) begin
      result_o          = FP_QNAN; // inf - inf
      fflags_o          = '0;
      fflags_o[FLAG_NV] = 1'b1;
    end else if (a_inf) begin
      result_o = {a_sign, FP_EXP_MAX, fp_frac_t'(0)};
      fflags_o = '0;
    end else if (b_inf) begin
      result_o = {b_sign_eff, FP_EXP_MAX, fp_frac_t'(0)};
      fflags_o = '0;
    end
  end

endmodule

`default_nettype wire

/* design/fp_types_pkg.sv */
// Binary32 field widths and word types shared by the add/sub datapath
// Imported by wildcard in every RTL module that handles operand words
`default_nettype none

package fp_types_pkg;

  // Field widths of the binary32 format
  localparam int unsigned FP_WORD_W = 32;
  localparam int unsigned FP_EXP_W  = 8;
  localparam int unsigned FP_FRAC_W = 23;
  localparam int unsigned FP_GRS_W  = 3; // Guard, round, sticky

  // Hidden bit + fraction + rounding bits
  localparam int unsigned FP_MANT_EXT_W = 1 + FP_FRAC_W + FP_GRS_W;

  // Packed word as sign, exponent, fraction
  typedef logic [FP_WORD_W-1:0] fp32_t;

  // Biased exponent
  typedef logic [FP_EXP_W-1:0] fp_exp_t;

  // Stored fraction without the hidden bit
  typedef logic [FP_FRAC_W-1:0] fp_frac_t;

  // Working mantissa from the aligner into the core
  typedef logic [FP_MANT_EXT_W-1:0] fp_mant_ext_t;

  // Exponent of infinities and NaNs
  localparam fp_exp_t FP_EXP_MAX = '1;

  // Canonical quiet NaN, positive sign and fraction MSB set
  localparam fp32_t FP_QNAN = {1'b0, FP_EXP_MAX, 1'b1, {(FP_FRAC_W-1){1'b0}}};

endpackage

`default_nettype wire

/* design/fpu_addsub_unit.sv */
// Single-precision add/sub unit with one output register and sticky flags
// Takes a valid strobe per operation and returns the result one clock later
`default_nettype none

module fpu_addsub_unit
  import fp_types_pkg::*;
  import fp_ctrl_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    valid_i,      // One-cycle strobe per operation
  input  fp32_t   rs1_i,
  input  fp32_t   rs2_i,
  input  logic    sub_i,        // rs1 - rs2 when set
  input  frm_e    frm_i,
  input  logic    flags_clr_i,  // Clears the accrued flags
  output logic    valid_o,
  output fp32_t   result_o,
  output fflags_t fflags_o,     // Flags of the last operation
  output fflags_t fflags_acc_o  // Sticky OR since the last clear
);

  fp32_t   core_result, final_result;
  fflags_t core_fflags, final_fflags;

  fp_addsub u_addsub (
    .a_i      (rs1_i),
    .b_i      (rs2_i),
    .sub_i    (sub_i),
    .frm_i    (frm_i),
    .result_o (core_result),
    .fflags_o (core_fflags)
  );

  fp_special_case u_special_case (
    .a_i           (rs1_i),
    .b_i           (rs2_i),
    .sub_i         (sub_i),
    .core_result_i (core_result),
    .core_fflags_i (core_fflags),
    .result_o      (final_result),
    .fflags_o      (final_fflags)
  );

  // Result holds until the next accepted operation
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_o  <= 1'b0;
      result_o <= '0;
      fflags_o <= '0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        result_o <= final_result;
        fflags_o <= final_fflags;
      end
    end
  end

  // Clear wins over the old value, new flags still get in
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      fflags_acc_o <= '0;
    end else if (flags_clr_i) begin
      fflags_acc_o <= valid_i ? final_fflags : '0;
    end else if (valid_i) begin
      fflags_acc_o <= fflags_acc_o | final_fflags;
    end
  end

  // Two results in a row need two accepted operations in a row
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (valid_o && $past(valid_o)) |-> ($past(valid_i) && $past(valid_i, 2)))
    else $error("valid_o held without matching valid_i");

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Compile with Verilator, run the testbench and decide the verdict from the log
rm -f sim.log
verilator --binary --assert --top-module tb_fpu_addsub -f src.f -o tb_fpu_addsub \
  && ./obj_dir/tb_fpu_addsub | tee sim.log
grep -q "RESULT: PASS" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

/* src.f */
design/fp_types_pkg.sv
design/fp_ctrl_pkg.sv
design/fp_lead_one.sv
design/fp_align.sv
design/fp_addsub.sv
design/fp_special_case.sv
design/fpu_addsub_unit.sv
tests/tb_fpu_addsub.sv

/* tests/tb_fpu_addsub.sv */
// Directed testbench for the single-precision add/sub unit
// Runs exact integer sums, rounding, zero, overflow, special and accrued-flag cases
`default_nettype none

module tb_fpu_addsub
  import fp_types_pkg::*;
  import fp_ctrl_pkg::*;
();

  localparam int unsigned SEED       = 32'hef15_1485;
  localparam int          N_RANDOM   = 200;
  localparam int          N_STREAM   = 20;   // Tail of the random ops sent back to back
  localparam int          N_OPS      = 229;  // All operations issued by the tests
  localparam int          VALID_WAIT = 8;    // Cycles to wait for valid_o
  localparam int          WATCHDOG_TIME = (N_OPS + 20) * 10 * 4;

  localparam fp32_t ONE       = 32'h3F80_0000;
  localparam fp32_t ONE_ULP   = 32'h3F80_0001; // 1.0 plus one ulp
  localparam fp32_t HALF_ULP  = 32'h3380_0000; // 2^-24
  localparam fp32_t NEG_ONE   = 32'hBF80_0000;
  localparam fp32_t NEG_ULP   = 32'hBF80_0001;
  localparam fp32_t NEG_HALF  = 32'hB380_0000;
  localparam fp32_t X_VAL     = 32'h4060_0000; // 3.5
  localparam fp32_t NEG_X_VAL = 32'hC060_0000;
  localparam fp32_t MAX_FIN   = 32'h7F7F_FFFF;
  localparam fp32_t POS_INF   = 32'h7F80_0000;
  localparam fp32_t QNAN_IN   = 32'h7FC0_0000;
  localparam fp32_t SNAN_IN   = 32'h7F80_0001; // Quiet bit clear
  localparam fflags_t F_NV = 5'b10000;
  localparam fflags_t F_OF = 5'b00100;
  localparam fflags_t F_NX = 5'b00001;

  logic    clk_i, rst_n_i, valid_i, sub_i, flags_clr_i;
  fp32_t   rs1_i, rs2_i;
  frm_e    frm_i;
  logic    valid_o;
  fp32_t   result_o;
  fflags_t fflags_o, fflags_acc_o;

  int      checks;
  int      errors;
  fflags_t acc_model; // Expected accrued flags

  fpu_addsub_unit DUT (
    .clk_i, .rst_n_i, .valid_i, .rs1_i, .rs2_i, .sub_i, .frm_i, .flags_clr_i,
    .valid_o, .result_o, .fflags_o, .fflags_acc_o
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("Timeout: run did not finish within %0d time units", WATCHDOG_TIME);
    $display("RESULT: FAIL");
    $finish;
  end

  // Exact binary32 encoding of an integer below 2^24
  function automatic fp32_t int_to_fp(input int v);
    logic [31:0] mag;
    int          msb;
    fp32_t       w;
    mag = (v < 0) ? 32'(-v) : 32'(v);
    msb = 0;
    for (int i = 0; i < 24; i++) begin
      if (mag[i]) msb = i;
    end
    w[31]    = (v < 0);
    w[30:23] = 8'(127 + msb);
    w[22:0]  = 23'(mag << (23 - msb)); // Hidden bit drops out
    if (mag == 0) w = '0;
    return w;
  endfunction

  task automatic check_result(input string name, input fp32_t exp_val, input fp32_t act_val);
    checks++;
    if (act_val !== exp_val) begin
      errors++;
      $display("Error %s: expected %h, actual %h", name, exp_val, act_val);
    end
  endtask

  task automatic check_flags(input string name, input fflags_t exp_val, input fflags_t act_val);
    checks++;
    if (act_val !== exp_val) begin
      errors++;
      $display("Error %s: expected %b, actual %b", name, exp_val, act_val);
    end
  endtask

  // Called right after a falling edge
  task automatic drive_op(input fp32_t a, input fp32_t b, input logic sub, input frm_e frm,
                          input logic clr, input fflags_t exp_flags);
    valid_i     = 1'b1;
    rs1_i       = a;
    rs2_i       = b;
    sub_i       = sub;
    frm_i       = frm;
    flags_clr_i = clr;
    acc_model   = clr ? exp_flags : (acc_model | exp_flags); // Clear first and then OR
  endtask

  task automatic run_op(input string name, input fp32_t a, input fp32_t b, input logic sub,
                        input frm_e frm, input logic clr, input fp32_t exp_res,
                        input fflags_t exp_flags);
    int cycles;
    @(negedge clk_i);
    if (valid_o) begin
      errors++;
      $display("%s: valid_o still high from the previous operation", name);
    end
    drive_op(a, b, sub, frm, clr, exp_flags);
    cycles = 0;
    do begin
      @(negedge clk_i);
      valid_i     = 1'b0;
      flags_clr_i = 1'b0;
      cycles++;
    end while (!valid_o && cycles < VALID_WAIT);
    if (!valid_o) begin
      errors++;
      $display("%s: valid_o never rose within %0d cycles", name, VALID_WAIT);
    end else begin
      if (cycles != 1) begin
        errors++;
        $display("%s: valid_o came %0d cycles after valid_i instead of 1", name, cycles);
      end
      check_result(name, exp_res, result_o);
      check_flags(name, exp_flags, fflags_o);
      check_flags({name, " acc"}, acc_model, fflags_acc_o);
    end
  endtask

  task automatic clear_flags(input string name);
    @(negedge clk_i);
    flags_clr_i = 1'b1;
    acc_model   = '0;
    @(negedge clk_i);
    flags_clr_i = 1'b0;
    check_flags(name, 5'b00000, fflags_acc_o);
    if (valid_o) begin
      errors++;
      $display("%s: valid_o rose without an operation", name);
    end
  endtask

  // Random integers with nonzero magnitude below 2^20
  task automatic random_op(output fp32_t a, output fp32_t b, output logic sub,
                           output frm_e frm, output fp32_t exp_res);
    int x, y, r;
    x = int'($urandom % 32'h000F_FFFF) + 1;
    y = int'($urandom % 32'h000F_FFFF) + 1;
    if ($urandom % 2) x = -x;
    if ($urandom % 2) y = -y;
    sub = 1'($urandom);
    frm = frm_e'(3'($urandom % 5));
    r   = sub ? x - y : x + y;
    a   = int_to_fp(x);
    b   = int_to_fp(y);
    exp_res = (r == 0) ? fp32_t'({frm == RDN, 31'b0}) : int_to_fp(r); // Cancellation zero
  endtask

  task automatic test_exact_integers();
    fp32_t a, b, exp_res, prev_res;
    logic  sub;
    frm_e  frm;
    for (int i = 0; i < N_RANDOM - N_STREAM; i++) begin
      random_op(a, b, sub, frm, exp_res);
      run_op($sformatf("int %0d", i), a, b, sub, frm, 1'b0, exp_res, '0);
    end
    prev_res = '0;
    for (int i = 0; i <= N_STREAM; i++) begin
      @(negedge clk_i);
      if (i > 0) begin // Result of the op driven one cycle earlier
        if (!valid_o) begin
          errors++;
          $display("int stream %0d: valid_o low during back-to-back operations", i - 1);
        end
        check_result($sformatf("int stream %0d", i - 1), prev_res, result_o);
        check_flags($sformatf("int stream %0d", i - 1), '0, fflags_o);
        check_flags($sformatf("int stream %0d acc", i - 1), acc_model, fflags_acc_o);
      end
      if (i < N_STREAM) begin
        random_op(a, b, sub, frm, prev_res);
        drive_op(a, b, sub, frm, 1'b0, '0);
      end else begin
        valid_i = 1'b0;
      end
    end
  endtask

  task automatic test_rounding_modes();
    run_op("tie rne", ONE, HALF_ULP, 1'b0, RNE, 1'b0, ONE, F_NX);      // Ties to even
    run_op("tie rtz", ONE, HALF_ULP, 1'b0, RTZ, 1'b0, ONE, F_NX);
    run_op("tie rmm", ONE, HALF_ULP, 1'b0, RMM, 1'b0, ONE_ULP, F_NX);
    run_op("tie rup", ONE, HALF_ULP, 1'b0, RUP, 1'b0, ONE_ULP, F_NX);
    run_op("tie rdn", ONE, HALF_ULP, 1'b0, RDN, 1'b0, ONE, F_NX);
    run_op("neg tie rup", NEG_ONE, NEG_HALF, 1'b0, RUP, 1'b0, NEG_ONE, F_NX);
    run_op("neg tie rdn", NEG_ONE, NEG_HALF, 1'b0, RDN, 1'b0, NEG_ULP, F_NX);
  endtask

  task automatic test_signed_zero();
    frm_e  frm;
    fp32_t zero;
    for (int m = 0; m < 5; m++) begin
      frm  = frm_e'(3'(m));
      zero = (frm == RDN) ? 32'h8000_0000 : 32'h0000_0000;
      run_op($sformatf("cancel add frm %0d", m), X_VAL, NEG_X_VAL, 1'b0, frm, 1'b0, zero, '0);
      run_op($sformatf("cancel sub frm %0d", m), X_VAL, X_VAL, 1'b1, frm, 1'b0, zero, '0);
    end
  endtask

  task automatic test_overflow_subnormal();
    run_op("overflow", MAX_FIN, MAX_FIN, 1'b0, RNE, 1'b0, POS_INF, F_OF | F_NX);
    run_op("subnormal", 32'h0000_0001, 32'h0000_0002, 1'b0, RNE, 1'b0, 32'h0000_0003, '0);
  endtask

  task automatic test_special_inputs();
    run_op("qnan", QNAN_IN, ONE, 1'b0, RNE, 1'b0, FP_QNAN, '0);
    run_op("snan", ONE, SNAN_IN, 1'b0, RNE, 1'b0, FP_QNAN, F_NV);
    run_op("inf minus inf", POS_INF, POS_INF, 1'b1, RNE, 1'b0, FP_QNAN, F_NV);
    run_op("inf plus one", POS_INF, ONE, 1'b0, RNE, 1'b0, POS_INF, '0);
    run_op("reserved frm", ONE, ONE, 1'b0, frm_e'(3'd5), 1'b0, FP_QNAN, F_NV);
  endtask

  task automatic test_accrued_flags();
    clear_flags("acc clear start");
    run_op("acc nx", ONE, HALF_ULP, 1'b0, RNE, 1'b0, ONE, F_NX);
    run_op("acc of", MAX_FIN, MAX_FIN, 1'b0, RNE, 1'b0, POS_INF, F_OF | F_NX);
    run_op("acc nv", SNAN_IN, ONE, 1'b0, RNE, 1'b0, FP_QNAN, F_NV);
    check_flags("acc sequence", F_NV | F_OF | F_NX, fflags_acc_o);
    clear_flags("acc clear alone");
    run_op("acc nx again", ONE, HALF_ULP, 1'b0, RUP, 1'b0, ONE_ULP, F_NX);
    // Clear and a new op in the same cycle keep only the new flags
    run_op("acc clear with op", ONE, ONE, 1'b0, frm_e'(3'd7), 1'b1, FP_QNAN, F_NV);
    check_flags("acc clear with op only", F_NV, fflags_acc_o);
  endtask

  initial begin
    void'($urandom(SEED));
    checks      = 0;
    errors      = 0;
    acc_model   = '0;
    rst_n_i     = 1'b0;
    valid_i     = 1'b0;
    rs1_i       = '0;
    rs2_i       = '0;
    sub_i       = 1'b0;
    frm_i       = RNE;
    flags_clr_i = 1'b0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    if (valid_o !== 1'b0) begin
      errors++;
      $display("reset: valid_o is not low after reset");
    end
    check_result("reset", '0, result_o);
    check_flags("reset", '0, fflags_o);
    check_flags("reset acc", '0, fflags_acc_o);
    test_exact_integers();
    test_rounding_modes();
    test_signed_zero();
    test_overflow_subnormal();
    test_special_inputs();
    test_accrued_flags();
    @(negedge clk_i);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
